// ==== Bender.yml ====
package:
  name: fm_synth

sources:
  - common/fm_pkg.sv
  - src/fm_op_attr.sv
  - src/fm_ch_attr.sv
  - fm_voice/fm_phase.sv
  - fm_voice/fm_eg.sv
  - fm_voice/fm_op.sv
  - src/fm_synth.sv
  - target: test
    files:
      - sim/fm_synth_tb.sv

// ==== common/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

    localparam int op_sel_w = 6;
    localparam int env_w    = 9;
    localparam int sample_w = 13;

    ////////////////////
    // Sequencer and envelope states
    typedef enum logic [2:0] {
        st_reset,
        st_reset2,
        st_log_sin,
        st_exp,
        st_result,
        st_done,
        st_bus,
        st_start
    } fm_state_t;

    typedef enum logic [1:0] {
        eg_attack,
        eg_decay,
        eg_sustain,
        eg_release
    } eg_state_t;

    ////////////////////
    // Attribute words

    // Word 1 in the upper half, word 0 in the lower half
    typedef struct packed {
        logic [3:0] rr;
        logic [3:0] sl;
        logic [3:0] dr;
        logic [3:0] ar;
        logic [5:0] tl;
        logic [1:0] ksl;
        logic [3:0] mult;
        logic       ksr;
        logic       egt;
        logic       vib;
        logic       am;
        logic [2:0] ws;
    } op_attr_t;

    typedef struct packed {
        logic       chb;
        logic       cha;
        logic [2:0] fb;
        logic       cnt;
        logic       kon;
        logic [2:0] block;
        logic [9:0] fnum;
    } ch_attr_t;

    typedef struct packed {
        logic nts;
        logic dam;
        logic dvb;
    } mode_t;

endpackage

`default_nettype wire

// ==== compile.f ====
common/fm_pkg.sv
src/fm_op_attr.sv
src/fm_ch_attr.sv
fm_voice/fm_phase.sv
fm_voice/fm_eg.sv
fm_voice/fm_op.sv
src/fm_synth.sv
sim/fm_synth_tb.sv

// ==== fm_voice/fm_eg.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_eg import fm_pkg::*; (
    input  wire                 clk,
    input  wire  [op_sel_w-1:0] op_sel,
    input  wire                 next,
    input  wire                 op_reset,
    input  wire                 restart,
    input  wire  ch_attr_t      ch,
    input  wire  op_attr_t      op,
    input  wire  mode_t         mode,
    output logic [env_w-1:0]    env
);

    localparam logic [env_w-1:0] silent = '1;

    eg_state_t        state_mem [2**op_sel_w];
    logic [env_w-1:0] att_mem   [2**op_sel_w];
    eg_state_t        state;
    eg_state_t        state_eff;
    eg_state_t        state_n;
    logic [env_w-1:0] att;
    logic [env_w-1:0] att_n;
    logic [3:0]       ksn;
    logic [3:0]       rof;
    logic [14:0]      atk_prod;
    logic [env_w-1:0] atk_step;
    logic [env_w-1:0] sl_level;
    logic [env_w-1:0] dr_level;
    logic [env_w:0]   tl_sum;

    // Rate 4*r plus key scale offset, capped at 63
    function automatic logic [5:0] eff_rate(input logic [3:0] r, input logic [3:0] ofs);
        logic [6:0] sum;
        sum = {1'b0, r, 2'b00} + {3'b0, ofs};
        if (r == 4'd0) begin
            return 6'd0;
        end
        return (sum > 7'd63) ? 6'd63 : sum[5:0];
    endfunction

    function automatic logic [env_w-1:0] rise(input logic [env_w-1:0] a, input logic [5:0] rate);
        logic [env_w:0] sum;
        sum = {1'b0, a} + {6'b0, rate[5:2]};
        return sum[env_w] ? silent : sum[env_w-1:0];
    endfunction

    assign state     = state_mem[op_sel];
    assign att       = att_mem[op_sel];
    assign ksn       = {ch.block, mode.nts ? ch.fnum[8] : ch.fnum[9]};
    assign rof       = op.ksr ? ksn : {2'b00, ksn[3:2]};
    assign state_eff = ch.kon ? state : eg_release;
    assign atk_prod  = att * eff_rate(op.ar, rof);
    assign atk_step  = {2'b00, atk_prod[14:8]} + 1'b1;
    assign sl_level  = {1'b0, op.sl, 4'b0000};
    assign dr_level  = rise(att, eff_rate(op.dr, rof));

    always_comb begin
        state_n = state_eff;
        att_n   = att;
        case (state_eff)
            eg_attack: begin
                if (op.ar == 4'd15 || (op.ar != 4'd0 && att <= atk_step)) begin
                    att_n   = '0;
                    state_n = eg_decay;
                end else if (op.ar != 4'd0) begin
                    att_n = att - atk_step;
                end
            end
            eg_decay: begin
                if (dr_level >= sl_level) begin
                    att_n   = sl_level;
                    state_n = eg_sustain;
                end else begin
                    att_n = dr_level;
                end
            end
            // Held only for sustained tones
            eg_sustain: begin
                if (!op.egt) begin
                    state_n = eg_release;
                end
            end
            default: begin
                if (att == silent || op.rr == 4'd15) begin
                    att_n = silent;
                end else begin
                    att_n = rise(att, eff_rate(op.rr, rof));
                end
            end
        endcase
        if (restart) begin
            state_n = eg_attack;
            att_n   = att;
        end
        if (op_reset) begin
            state_n = eg_release;
            att_n   = silent;
        end
    end

    always_ff @(posedge clk) begin
        if (next) begin
            state_mem[op_sel] <= state_n;
            att_mem[op_sel]   <= att_n;
        end
    end

    // Total level adds 0.75 dB per step
    assign tl_sum = {1'b0, att} + {2'b00, op.tl, 2'b00};
    assign env    = (att == silent || tl_sum[env_w]) ? silent : tl_sum[env_w-1:0];

endmodule

`default_nettype wire

// ==== fm_voice/fm_op.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_op import fm_pkg::*; (
    input  wire                        clk,
    input  wire  [2:0]                 ws,
    input  wire  [9:0]                 phase,
    input  wire  [env_w-1:0]           env,
    output logic signed [sample_w-1:0] result
);

    logic [7:0]  idx;
    logic [9:0]  u;
    logic [17:0] sq;
    logic [4:0]  lead;
    logic [17:0] norm;
    logic [4:0]  octave;
    logic [11:0] logsin;
    logic [12:0] q_att;
    logic        q_neg;
    logic        q_zero;
    logic [12:0] mant;
    logic [5:0]  shamt;
    logic [12:0] shifted;

    ////////////////////
    // Stage 1: log-sine plus attenuation

    // Mirror the second quarter
    assign idx = phase[8] ? ~phase[7:0] : phase[7:0];
    assign u   = {1'b0, idx, 1'b1};
    // Parabolic sine, u*(1024-u) scaled by 2^18
    assign sq  = u * (11'd1024 - {1'b0, u});

    always_comb begin
        lead = '0;
        for (int i = 0; i < 18; i++) begin
            if (sq[i]) begin
                lead = 5'(i);
            end
        end
    end

    // -log2 in 4.8 fixed point, mantissa taken as linear
    assign norm   = sq << (5'd17 - lead);
    assign octave = 5'd18 - lead;
    assign logsin = {octave[3:0], 8'd0} - {4'd0, norm[16:9]};

    always_ff @(posedge clk) begin
        q_att  <= {1'b0, logsin} + {1'b0, env, 3'b000};
        q_neg  <= phase[9];
        q_zero <= (env == '1) || (ws == 3'd1 && phase[9]);
    end

    ////////////////////
    // Stage 2: exponent and sign
    assign mant    = 13'd8191 - {1'b0, q_att[7:0], 4'b0000};
    assign shamt   = {1'b0, q_att[12:8]} + 1'b1;
    assign shifted = mant >> shamt;

    always_ff @(posedge clk) begin
        if (q_zero) begin
            result <= '0;
        end else if (q_neg) begin
            result <= -$signed({1'b0, shifted[11:0]});
        end else begin
            result <= $signed({1'b0, shifted[11:0]});
        end
    end

endmodule

`default_nettype wire

// ==== fm_voice/fm_phase.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_phase import fm_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [op_sel_w-1:0] op_sel,
    input  wire                 next,
    input  wire                 op_reset,
    input  wire                 restart,
    input  wire  ch_attr_t      ch,
    input  wire  op_attr_t      op,
    input  wire  mode_t         mode,
    output logic [9:0]          phase
);

    logic [19:0] acc_mem [2**op_sel_w];
    logic [16:0] base;
    logic [4:0]  mult2;
    logic [21:0] prod;
    logic [19:0] q_inc;

    // Step in half units so that mult 0 gives one half
    assign base  = {7'b0, ch.fnum} << ch.block;
    assign mult2 = (op.mult == 4'd0) ? 5'd1 : {op.mult, 1'b0};
    assign prod  = base * mult2;

    // Settled long before the write at the end of the slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_inc <= '0;
        end else begin
            q_inc <= prod[20:1];
        end
    end

    always_ff @(posedge clk) begin
        if (next) begin
            if (op_reset || restart) begin
                acc_mem[op_sel] <= '0;
            end else begin
                acc_mem[op_sel] <= acc_mem[op_sel] + q_inc;
            end
        end
    end

    assign phase = acc_mem[op_sel][19:10];

endmodule

`default_nettype wire

// ==== sim/fm_cases.txt ====
// kind addr data expect; kind 0 write, 1 read, 2 random write and readback (expect is mask)
// kind 3 audio: addr = frames to settle, data = frames checked, expect 1 = tone, 0 = silence
1e // case count
3 00 00000002 00000000
0 00 12345678 00000000
1 00 00000000 00005678
0 01 ffffffff 00000000
1 01 00000000 000040c0
0 01 00000000 00000000
1 01 00000000 00000000
1 02 00000000 00000000
1 50 00000000 00000000
0 fc fff800a0 00000000
1 fc 00000000 000000a0
0 fd 0000000f 00000000
0 fe 000000a0 00000000
0 ff ffff000f 00000000
1 ff 00000000 0000000f
0 7f 00003200 00000000
1 7f 00000000 00003200
3 00 00000003 00000001
0 7f 00003300 00000000
1 7f 00000000 00003300
3 00 00000002 00000001
0 fd 0000f00f 00000000
0 ff 0000f00f 00000000
0 7f 00001300 00000000
3 02 00000001 00000000
2 00 00000000 0000ffff
2 01 00000000 000040c0
2 65 00000000 000fffff
2 90 00000000 0007ffff
2 91 00000000 0000ffff

// ==== sim/fm_synth_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_synth_tb;

    localparam int clk_period   = 100;
    localparam int frame_cycles = 258;
    localparam int case_cycles  = 300;
    localparam int max_words    = 512;

    logic        clk;
    logic        reset;
    logic [7:0]  bus_addr;
    logic [31:0] bus_wrdata;
    logic        bus_wren;
    logic [31:0] bus_rddata;
    logic        bus_wait;
    logic [15:0] audio_l;
    logic [15:0] audio_r;

    logic [31:0] case_mem [max_words];
    logic [31:0] lfsr;
    int          n_cases = 0;
    int          errors = 0;
    int          n_failed = 0;
    int          case_err;

    fm_synth dut_i (
        .clk        (clk),
        .reset      (reset),
        .bus_addr   (bus_addr),
        .bus_wrdata (bus_wrdata),
        .bus_wren   (bus_wren),
        .bus_rddata (bus_rddata),
        .bus_wait   (bus_wait),
        .audio_l    (audio_l),
        .audio_r    (audio_r)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////
    // Helpers

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic next_random(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic bus_write(input int idx, input logic [7:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        bus_addr   <= addr;
        bus_wrdata <= data;
        bus_wren   <= 1'b1;
        // Hold until the sequencer reaches its bus slot
        do begin
            @(negedge clk);
            n++;
        end while (bus_wait && n < frame_cycles);
        if (bus_wait) begin
            $display("case %0d: write to address %h not accepted within %0d cycles",
                     idx, addr, frame_cycles);
            case_err++;
        end
        @(negedge clk);
        bus_wren <= 1'b0;
    endtask

    task automatic bus_read(input int idx, input logic [7:0] addr, input logic [31:0] expected);
        bus_addr <= addr;
        bus_wren <= 1'b0;
        @(negedge clk);
        if (bus_rddata !== expected) begin
            $display("** Error: case %0d bus_rddata = %h, expected %h", idx, bus_rddata, expected);
            case_err++;
        end
    endtask

    task automatic audio_check(input int idx, input int settle, input int frames,
                               input logic want_tone);
        logic heard;
        logic bad_form;
        heard    = 1'b0;
        bad_form = 1'b0;
        repeat (settle * frame_cycles) @(negedge clk);
        for (int c = 0; c < frames * frame_cycles; c++) begin
            @(negedge clk);
            // Mono output, shifted left by three
            if (!bad_form && ($isunknown(audio_l) || audio_l !== audio_r
                              || audio_l[2:0] !== 3'b000)) begin
                $display("** Error: case %0d audio_l = %h, audio_r = %h", idx, audio_l, audio_r);
                bad_form = 1'b1;
                case_err++;
            end
            if (audio_l !== 16'h0000) begin
                if (!want_tone && !heard) begin
                    $display("** Error: case %0d audio_l = %h, expected 0000", idx, audio_l);
                    case_err++;
                end
                heard = 1'b1;
            end
        end
        if (want_tone && !heard) begin
            $display("case %0d: audio stayed silent across %0d frames", idx, frames);
            case_err++;
        end
    endtask

    ////////////////////
    // bus_wait only answers a pending write
    always @(negedge clk) begin
        if (!reset && !bus_wren && bus_wait) begin
            $display("bus_wait high at %0t while no write is pending", $time);
            errors++;
        end
    end

    initial begin
        wait (n_cases > 0);
        #(n_cases * case_cycles * clk_period);
        $display("Run stopped by the watchdog after %0d cycles", n_cases * case_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic [31:0] rnd;
        clk        = 1'b0;
        reset      = 1'b1;
        bus_addr   = '0;
        bus_wrdata = '0;
        bus_wren   = 1'b0;
        lfsr       = 32'h7fbb_1b48;
        $readmemh("sim/fm_cases.txt", case_mem);
        if ($isunknown(case_mem[0]) || case_mem[0] == 0 || case_mem[0] > (max_words - 1) / 4) begin
            $display("Cases file is missing or has no valid case count");
            errors++;
        end else begin
            n_cases = case_mem[0];
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;

        for (int i = 0; i < n_cases; i++) begin
            kind     = case_mem[1 + 4 * i];
            addr     = case_mem[2 + 4 * i];
            data     = case_mem[3 + 4 * i];
            expected = case_mem[4 + 4 * i];
            case_err = 0;
            @(negedge clk);
            case (kind)
                0: bus_write(i, addr[7:0], data);
                1: bus_read(i, addr[7:0], expected);
                2: begin
                    next_random(rnd);
                    bus_write(i, addr[7:0], rnd);
                    bus_read(i, addr[7:0], rnd & expected);
                end
                3: audio_check(i, addr, data, expected[0]);
                default: begin
                    $display("case %0d: unknown case kind %0d", i, kind);
                    case_err++;
                end
            endcase
            errors += case_err;
            if (case_err != 0) begin
                n_failed++;
            end
            $display("case %0d kind %0d addr %h: %s", i, kind, addr[7:0],
                     (case_err == 0) ? "ok" : "failed");
        end

        $display("%0d cases run, %0d failed, %0d errors", n_cases, n_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fm_ch_attr.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_ch_attr import fm_pkg::*; (
    input  wire         clk,
    input  wire  [4:0]  addr,
    input  wire  [31:0] wrdata,
    input  wire         wren,
    output logic [31:0] rddata,
    input  wire  [4:0]  ch_sel,
    output ch_attr_t    attr
);

    localparam int word_w = $bits(ch_attr_t);

    // One word per channel, fnum in the low bits
    logic [word_w-1:0] mem [32];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[addr] <= wrdata[word_w-1:0];
        end
    end

    assign rddata = {{(32-word_w){1'b0}}, mem[addr]};
    assign attr   = ch_attr_t'(mem[ch_sel]);

endmodule

`default_nettype wire

// ==== src/fm_op_attr.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_op_attr import fm_pkg::*; (
    input  wire                 clk,
    input  wire  [6:0]          addr,
    input  wire  [31:0]         wrdata,
    input  wire                 wren,
    output logic [31:0]         rddata,
    input  wire  [op_sel_w-1:0] op_sel,
    output op_attr_t            attr
);

    localparam int w0_w = 19;
    localparam int w1_w = 16;

    // Two words per operator, only the defined field bits
    logic [w0_w-1:0]     w0_mem [2**op_sel_w];
    logic [w1_w-1:0]     w1_mem [2**op_sel_w];
    logic [op_sel_w-1:0] bus_op;

    assign bus_op = addr[6:1];

    always_ff @(posedge clk) begin
        if (wren) begin
            if (addr[0]) begin
                w1_mem[bus_op] <= wrdata[w1_w-1:0];
            end else begin
                w0_mem[bus_op] <= wrdata[w0_w-1:0];
            end
        end
    end

    always_comb begin
        if (addr[0]) begin
            rddata = {{(32-w1_w){1'b0}}, w1_mem[bus_op]};
        end else begin
            rddata = {{(32-w0_w){1'b0}}, w0_mem[bus_op]};
        end
    end

    // Struct layout matches the concatenated words
    assign attr = op_attr_t'({w1_mem[op_sel], w0_mem[op_sel]});

endmodule

`default_nettype wire

// ==== src/fm_synth.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_synth import fm_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire  [7:0]  bus_addr,
    input  wire  [31:0] bus_wrdata,
    input  wire         bus_wren,
    output logic [31:0] bus_rddata,
    output logic        bus_wait,
    output logic [15:0] audio_l,
    output logic [15:0] audio_r
);

    fm_state_t                  q_state;
    logic [op_sel_w-1:0]        q_op_sel;
    logic                       q_next;
    logic                       q_op_reset;
    logic signed [sample_w-1:0] q_result;
    logic [15:0]                q_4op;
    mode_t                      q_mode;
    logic [31:0]                q_kon;
    logic [31:0]                q_restart;
    logic                       bus_wr;
    logic                       sel_reg0;
    logic                       sel_reg1;
    logic                       sel_ch;
    logic                       sel_op;
    logic [31:0]                ch_rddata;
    logic [31:0]                op_rddata;
    op_attr_t                   op_attr;
    ch_attr_t                   ch_attr;
    logic [op_sel_w-2:0]        ch_sel;
    logic                       restart;
    logic [9:0]                 phase;
    logic [env_w-1:0]           env;
    logic signed [sample_w-1:0] result;

    ////////////////////
    // Bus decode and global registers
    assign bus_wait = bus_wren && (q_state != st_bus);
    assign bus_wr   = bus_wren && !bus_wait;
    assign sel_reg0 = bus_addr == 8'd0;
    assign sel_reg1 = bus_addr == 8'd1;
    assign sel_ch   = bus_addr[7:5] == 3'b011;
    assign sel_op   = bus_addr[7];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_4op  <= '0;
            q_mode <= '0;
        end else begin
            if (bus_wr && sel_reg0) begin
                q_4op <= bus_wrdata[15:0];
            end
            if (bus_wr && sel_reg1) begin
                q_mode <= '{nts: bus_wrdata[14], dam: bus_wrdata[7], dvb: bus_wrdata[6]};
            end
        end
    end

    always_comb begin
        bus_rddata = '0;
        if (sel_reg0) begin
            bus_rddata = {16'b0, q_4op};
        end else if (sel_reg1) begin
            bus_rddata = {17'b0, q_mode.nts, 6'b0, q_mode.dam, q_mode.dvb, 6'b0};
        end else if (sel_ch) begin
            bus_rddata = ch_rddata;
        end else if (sel_op) begin
            bus_rddata = op_rddata;
        end
    end

    ////////////////////
    // Key-on tracking
    assign ch_sel  = q_op_sel[op_sel_w-1:1];
    assign restart = q_restart[ch_sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_kon     <= '0;
            q_restart <= '0;
        end else begin
            // Cleared once the second operator of the channel is updated
            if (q_state == st_done && q_op_sel[0]) begin
                q_restart[ch_sel] <= 1'b0;
            end
            if (bus_wr && sel_ch) begin
                q_kon[bus_addr[4:0]] <= bus_wrdata[13];
                if (bus_wrdata[13] && !q_kon[bus_addr[4:0]]) begin
                    q_restart[bus_addr[4:0]] <= 1'b1;
                end
            end
        end
    end

    fm_op_attr op_attr_i (
        .clk    (clk),
        .addr   (bus_addr[6:0]),
        .wrdata (bus_wrdata),
        .wren   (bus_wr && sel_op),
        .rddata (op_rddata),
        .op_sel (q_op_sel),
        .attr   (op_attr)
    );

    fm_ch_attr ch_attr_i (
        .clk    (clk),
        .addr   (bus_addr[4:0]),
        .wrdata (bus_wrdata),
        .wren   (bus_wr && sel_ch),
        .rddata (ch_rddata),
        .ch_sel (ch_sel),
        .attr   (ch_attr)
    );

    fm_phase phase_i (
        .clk      (clk),
        .reset    (reset),
        .op_sel   (q_op_sel),
        .next     (q_next),
        .op_reset (q_op_reset),
        .restart  (restart),
        .ch       (ch_attr),
        .op       (op_attr),
        .mode     (q_mode),
        .phase    (phase)
    );

    fm_eg eg_i (
        .clk      (clk),
        .op_sel   (q_op_sel),
        .next     (q_next),
        .op_reset (q_op_reset),
        .restart  (restart),
        .ch       (ch_attr),
        .op       (op_attr),
        .mode     (q_mode),
        .env      (env)
    );

    fm_op op_i (
        .clk    (clk),
        .ws     (op_attr.ws),
        .phase  (phase),
        .env    (env),
        .result (result)
    );

    ////////////////////
    // Sequencer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_state    <= st_reset;
            q_op_sel   <= '0;
            q_next     <= 1'b0;
            q_op_reset <= 1'b0;
            q_result   <= '0;
        end else begin
            q_next <= 1'b0;
            case (q_state)
                st_reset: begin
                    q_op_sel   <= '0;
                    q_op_reset <= 1'b1;
                    q_next     <= 1'b1;
                    q_state    <= st_reset2;
                end
                // One operator cleared per cycle
                st_reset2: begin
                    q_op_sel <= q_op_sel + 1'b1;
                    q_next   <= 1'b1;
                    if (q_op_sel == '1) begin
                        q_next     <= 1'b0;
                        q_op_reset <= 1'b0;
                        q_state    <= st_log_sin;
                    end
                end
                st_log_sin: q_state <= st_exp;
                st_exp:     q_state <= st_result;
                st_result: begin
                    q_result <= result;
                    q_next   <= 1'b1;
                    q_state  <= st_done;
                end
                st_done: begin
                    q_op_sel <= q_op_sel + 1'b1;
                    q_state  <= (q_op_sel == '1) ? st_bus : st_log_sin;
                end
                // Only slot where pending writes go through
                st_bus:   q_state <= st_start;
                st_start: q_state <= st_log_sin;
                default:  q_state <= st_reset;
            endcase
        end
    end

    assign audio_l = {q_result, 3'b000};
    assign audio_r = {q_result, 3'b000};

endmodule

`default_nettype wire
